// ==== verilog/rv_pkg.sv ====
/*
 * rv64i core shared definitions
 * register and index types, the two instruction views and their union,
 * ALU operation codes and the major opcodes the core decodes
 */

`default_nettype none

package rv_pkg;

  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] reg_t;
  typedef logic [4:0]      reg_idx_t;

  // fetch starts at this pc plus 4
  localparam reg_t RESET_PC_DEFAULT = 64'h7ffffffc;

  // R-type layout
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } inst_r_t;

  // I-type layout
  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } inst_i_t;

  // one instruction word, two readings
  typedef union packed {
    inst_r_t r;
    inst_i_t i;
  } inst_u;

  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_PASS = 3'd5
  } alu_op_e;

  // major opcodes
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

endpackage

`default_nettype wire

// ==== verilog/if_stage.sv ====
/*
 * instruction fetch stage
 * picks the next pc, runs the IDLE/ADDR/RETN request machine toward
 * instruction memory and holds the fetched word in the IF register
 */

`default_nettype none

module if_stage #(
  parameter rv_pkg::reg_t RESET_PC = rv_pkg::RESET_PC_DEFAULT
) (
  input  wire               clk,
  input  wire               rst,

  // toward decode
  output logic              if_to_id_valid,
  output rv_pkg::reg_t      if_to_id_pc,
  output logic [31:0]       if_to_id_inst,
  input  wire               id_allowin,

  // redirect from execute
  output logic              if_bj_ready,
  input  wire               bj_valid,
  input  wire               bj_ena,
  input  wire rv_pkg::reg_t bj_pc,

  // instruction memory
  output logic              imem_valid,
  output rv_pkg::reg_t      imem_addr,
  input  wire               imem_ready,
  input  wire rv_pkg::reg_t imem_rdata
);
  import rv_pkg::*;

  localparam logic [1:0] IDLE = 2'd0;
  localparam logic [1:0] ADDR = 2'd1;
  localparam logic [1:0] RETN = 2'd2;

  logic [1:0]  state;
  logic [1:0]  state_nxt;
  logic [31:0] fetch_inst;
  logic        if_valid;
  logic        if_allowin;
  logic        if_load;
  logic        bj_handshake;
  logic        mem_handshake;
  logic        flush;
  reg_t        if_pc;
  reg_t        next_pc;

  // redirects are only taken while nothing is in flight
  assign if_bj_ready   = state == IDLE;
  assign imem_valid    = state == ADDR;
  assign bj_handshake  = bj_valid && if_bj_ready;
  assign mem_handshake = imem_valid && imem_ready;
  assign flush         = bj_handshake && bj_ena;

  assign next_pc = bj_ena ? bj_pc : if_pc + reg_t'(4);

  assign if_allowin = !if_valid || id_allowin;
  assign if_load    = (state == RETN) && if_allowin;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:
        if (bj_handshake)
          state_nxt = ADDR;
      ADDR:
        if (mem_handshake)
          state_nxt = RETN;
      RETN:
        if (if_allowin)
          state_nxt = IDLE;
      default:
        state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // request address, stable for the whole ADDR phase
  always_ff @(posedge clk) begin
    if (bj_handshake) begin
      imem_addr <= next_pc;
    end
  end

  // word returned by memory, taken in the handshake cycle
  always_ff @(posedge clk) begin
    if (mem_handshake) begin
      fetch_inst <= imem_rdata[31:0];
    end
  end

  // IF register valid bit
  always_ff @(posedge clk) begin
    if (rst) begin
      if_valid <= 1'b0;
    end else if (flush) begin
      if_valid <= 1'b0;
    end else if (if_allowin) begin
      if_valid <= if_load;
    end
  end

  // if_pc also serves as the base for sequential next pc
  always_ff @(posedge clk) begin
    if (rst) begin
      if_pc <= RESET_PC;
    end else if (if_load) begin
      if_pc <= imem_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (if_load) begin
      if_to_id_inst <= fetch_inst;
    end
  end

  assign if_to_id_valid = if_valid;
  assign if_to_id_pc    = if_pc;

endmodule

`default_nettype wire

// ==== verilog/regfile.sv ====
/*
 * integer register file
 * 31 writable 64-bit registers, x0 reads as zero,
 * two combinational read ports and one write port
 */

`default_nettype none

module regfile (
  input  wire                   clk,
  input  wire                   rst,
  input  wire rv_pkg::reg_idx_t rs1,
  input  wire rv_pkg::reg_idx_t rs2,
  output rv_pkg::reg_t          rdata1,
  output rv_pkg::reg_t          rdata2,
  input  wire                   we,
  input  wire rv_pkg::reg_idx_t rd,
  input  wire rv_pkg::reg_t     wdata
);
  import rv_pkg::*;

  // no storage for x0
  reg_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = (rs1 == '0) ? reg_t'(0) : regs[rs1];
  assign rdata2 = (rs2 == '0) ? reg_t'(0) : regs[rs2];

endmodule

`default_nettype wire

// ==== verilog/id_stage.sv ====
/*
 * instruction decode stage
 * holds the ID register, reads the word through its R and I views,
 * builds immediates, reads operands and forms branch or jump targets
 */

`default_nettype none

module id_stage (
  input  wire                   clk,
  input  wire                   rst,

  // from fetch
  input  wire                   if_to_id_valid,
  input  wire rv_pkg::reg_t     if_to_id_pc,
  input  wire [31:0]            if_to_id_inst,
  output logic                  id_allowin,

  // register file read
  output rv_pkg::reg_idx_t      rs1,
  output rv_pkg::reg_idx_t      rs2,
  input  wire rv_pkg::reg_t     rdata1,
  input  wire rv_pkg::reg_t     rdata2,

  // toward execute
  output logic                  id_to_ex_valid,
  input  wire                   ex_allowin,
  output rv_pkg::reg_t          id_pc,
  output rv_pkg::alu_op_e       id_alu_op,
  output rv_pkg::reg_t          id_op_a,
  output rv_pkg::reg_t          id_op_b,
  output rv_pkg::reg_idx_t      id_rd,
  output logic                  id_we,
  output logic                  id_is_branch,
  output logic                  id_branch_ne,
  output logic                  id_is_jal,
  output rv_pkg::reg_t          id_target
);
  import rv_pkg::*;

  logic  id_valid;
  inst_u inst_q;
  logic  we_dec;
  reg_t  imm_i;
  reg_t  imm_b;
  reg_t  imm_u;
  reg_t  imm_j;

  assign id_allowin     = !id_valid || ex_allowin;
  assign id_to_ex_valid = id_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      id_valid <= 1'b0;
    end else if (id_allowin) begin
      id_valid <= if_to_id_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (if_to_id_valid && id_allowin) begin
      id_pc  <= if_to_id_pc;
      inst_q <= if_to_id_inst;
    end
  end

  assign rs1   = inst_q.i.rs1;
  assign rs2   = inst_q.r.rs2;
  assign id_rd = inst_q.r.rd;

  // immediates, all sign extended to XLEN
  assign imm_i = {{(XLEN-12){inst_q.i.imm12[11]}}, inst_q.i.imm12};
  assign imm_b = {{(XLEN-13){inst_q.r.funct7[6]}}, inst_q.r.funct7[6], inst_q.r.rd[0],
                  inst_q.r.funct7[5:0], inst_q.r.rd[4:1], 1'b0};
  assign imm_u = {{(XLEN-32){inst_q.r.funct7[6]}}, inst_q.r.funct7, inst_q.r.rs2,
                  inst_q.r.rs1, inst_q.r.funct3, 12'b0};
  assign imm_j = {{(XLEN-21){inst_q.i.imm12[11]}}, inst_q.i.imm12[11], inst_q.i.rs1,
                  inst_q.i.funct3, inst_q.i.imm12[0], inst_q.i.imm12[10:1], 1'b0};

  assign id_op_a = rdata1;

  always_comb begin
    id_alu_op    = ALU_ADD;
    id_op_b      = imm_i;
    we_dec       = 1'b0;
    id_is_branch = 1'b0;
    id_branch_ne = 1'b0;
    id_is_jal    = 1'b0;
    id_target    = id_pc + imm_b;
    case (inst_q.r.opcode)
      OP_IMM: begin
        we_dec = 1'b1;
        case (inst_q.i.funct3)
          3'b000:  id_alu_op = ALU_ADD;
          3'b111:  id_alu_op = ALU_AND;
          3'b110:  id_alu_op = ALU_OR;
          3'b100:  id_alu_op = ALU_XOR;
          default: we_dec = 1'b0;
        endcase
      end
      OP_REG: begin
        id_op_b = rdata2;
        we_dec  = 1'b1;
        case ({inst_q.r.funct7, inst_q.r.funct3})
          {7'b0000000, 3'b000}: id_alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: id_alu_op = ALU_SUB;
          {7'b0000000, 3'b111}: id_alu_op = ALU_AND;
          {7'b0000000, 3'b110}: id_alu_op = ALU_OR;
          {7'b0000000, 3'b100}: id_alu_op = ALU_XOR;
          default:              we_dec = 1'b0;
        endcase
      end
      OP_LUI: begin
        id_alu_op = ALU_PASS;
        id_op_b   = imm_u;
        we_dec    = 1'b1;
      end
      OP_BRANCH: begin
        id_op_b = rdata2;
        // only BEQ and BNE
        case (inst_q.r.funct3)
          3'b000: id_is_branch = 1'b1;
          3'b001: begin
            id_is_branch = 1'b1;
            id_branch_ne = 1'b1;
          end
          default: id_is_branch = 1'b0;
        endcase
      end
      OP_JAL: begin
        id_is_jal = 1'b1;
        we_dec    = 1'b1;
        id_target = id_pc + imm_j;
      end
      default: we_dec = 1'b0;
    endcase
  end

  // a write to x0 is no write at all
  assign id_we = we_dec && (inst_q.r.rd != '0);

endmodule

`default_nettype wire

// ==== verilog/ex_stage.sv ====
/*
 * execute stage
 * ALU, branch and jump resolution, register write-back, the retire report
 * and the redirect strobe that lets fetch start the next instruction
 */

`default_nettype none

module ex_stage (
  input  wire                    clk,
  input  wire                    rst,

  // from decode
  input  wire                    id_to_ex_valid,
  output logic                   ex_allowin,
  input  wire rv_pkg::reg_t      id_pc,
  input  wire rv_pkg::alu_op_e   id_alu_op,
  input  wire rv_pkg::reg_t      id_op_a,
  input  wire rv_pkg::reg_t      id_op_b,
  input  wire rv_pkg::reg_idx_t  id_rd,
  input  wire                    id_we,
  input  wire                    id_is_branch,
  input  wire                    id_branch_ne,
  input  wire                    id_is_jal,
  input  wire rv_pkg::reg_t      id_target,

  // redirect to fetch
  output logic                   bj_valid,
  output logic                   bj_ena,
  output rv_pkg::reg_t           bj_pc,
  input  wire                    if_bj_ready,

  // register write-back
  output logic                   wb_we,
  output rv_pkg::reg_idx_t       wb_rd,
  output rv_pkg::reg_t           wb_data,

  // retire report
  output logic                   retire_valid,
  output rv_pkg::reg_t           retire_pc,
  output rv_pkg::reg_idx_t       retire_rd,
  output rv_pkg::reg_t           retire_data
);
  import rv_pkg::*;

  logic     ex_valid;
  reg_t     pc_q;
  alu_op_e  alu_op_q;
  reg_t     op_a_q;
  reg_t     op_b_q;
  reg_idx_t rd_q;
  logic     we_q;
  logic     is_branch_q;
  logic     branch_ne_q;
  logic     is_jal_q;
  reg_t     target_q;
  reg_t     alu_out;
  reg_t     result;
  logic     taken;

  // one instruction at a time, wait for fetch to take the redirect
  assign ex_allowin = !ex_valid && !bj_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= id_to_ex_valid && ex_allowin;
    end
  end

  always_ff @(posedge clk) begin
    if (id_to_ex_valid && ex_allowin) begin
      pc_q        <= id_pc;
      alu_op_q    <= id_alu_op;
      op_a_q      <= id_op_a;
      op_b_q      <= id_op_b;
      rd_q        <= id_rd;
      we_q        <= id_we;
      is_branch_q <= id_is_branch;
      branch_ne_q <= id_branch_ne;
      is_jal_q    <= id_is_jal;
      target_q    <= id_target;
    end
  end

  always_comb begin
    case (alu_op_q)
      ALU_ADD:  alu_out = op_a_q + op_b_q;
      ALU_SUB:  alu_out = op_a_q - op_b_q;
      ALU_AND:  alu_out = op_a_q & op_b_q;
      ALU_OR:   alu_out = op_a_q | op_b_q;
      ALU_XOR:  alu_out = op_a_q ^ op_b_q;
      ALU_PASS: alu_out = op_b_q;
      default:  alu_out = op_a_q + op_b_q;
    endcase
  end

  // link value for JAL
  assign result = is_jal_q ? pc_q + reg_t'(4) : alu_out;

  assign taken = is_jal_q ||
                 (is_branch_q && ((op_a_q == op_b_q) != branch_ne_q));

  assign wb_we   = ex_valid && we_q;
  assign wb_rd   = rd_q;
  assign wb_data = result;

  assign retire_valid = ex_valid;
  assign retire_pc    = pc_q;
  assign retire_rd    = wb_we ? rd_q : reg_idx_t'(0);
  assign retire_data  = wb_we ? result : reg_t'(0);

  // pending after reset so the first fetch starts
  always_ff @(posedge clk) begin
    if (rst) begin
      bj_valid <= 1'b1;
      bj_ena   <= 1'b0;
    end else if (ex_valid) begin
      bj_valid <= 1'b1;
      bj_ena   <= taken;
    end else if (bj_valid && if_bj_ready) begin
      bj_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      bj_pc <= target_q;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/core_top.sv ====
/*
 * rv64i core top level
 * fetch, decode and execute stages around the register file,
 * with the instruction memory port and the retire report
 */

`default_nettype none

module core_top #(
  parameter rv_pkg::reg_t RESET_PC = rv_pkg::RESET_PC_DEFAULT
) (
  input  wire                    clk,
  input  wire                    rst,

  output wire                    imem_valid,
  output wire rv_pkg::reg_t      imem_addr,
  input  wire                    imem_ready,
  input  wire rv_pkg::reg_t      imem_rdata,

  output wire                    retire_valid,
  output wire rv_pkg::reg_t      retire_pc,
  output wire rv_pkg::reg_idx_t  retire_rd,
  output wire rv_pkg::reg_t      retire_data
);
  import rv_pkg::*;

  // fetch and decode
  wire           if_to_id_valid;
  wire reg_t     if_to_id_pc;
  wire [31:0]    if_to_id_inst;
  wire           id_allowin;

  // redirect
  wire           bj_valid;
  wire           bj_ena;
  wire reg_t     bj_pc;
  wire           if_bj_ready;

  // register file
  wire reg_idx_t rs1;
  wire reg_idx_t rs2;
  wire reg_t     rdata1;
  wire reg_t     rdata2;
  wire           wb_we;
  wire reg_idx_t wb_rd;
  wire reg_t     wb_data;

  // decode and execute
  wire           id_to_ex_valid;
  wire           ex_allowin;
  wire reg_t     id_pc;
  wire alu_op_e  id_alu_op;
  wire reg_t     id_op_a;
  wire reg_t     id_op_b;
  wire reg_idx_t id_rd;
  wire           id_we;
  wire           id_is_branch;
  wire           id_branch_ne;
  wire           id_is_jal;
  wire reg_t     id_target;

  if_stage #(.RESET_PC(RESET_PC)) u_if (
    .clk(clk), .rst(rst),
    .if_to_id_valid(if_to_id_valid), .if_to_id_pc(if_to_id_pc),
    .if_to_id_inst(if_to_id_inst), .id_allowin(id_allowin),
    .if_bj_ready(if_bj_ready), .bj_valid(bj_valid), .bj_ena(bj_ena), .bj_pc(bj_pc),
    .imem_valid(imem_valid), .imem_addr(imem_addr),
    .imem_ready(imem_ready), .imem_rdata(imem_rdata)
  );

  id_stage u_id (
    .clk(clk), .rst(rst),
    .if_to_id_valid(if_to_id_valid), .if_to_id_pc(if_to_id_pc),
    .if_to_id_inst(if_to_id_inst), .id_allowin(id_allowin),
    .rs1(rs1), .rs2(rs2), .rdata1(rdata1), .rdata2(rdata2),
    .id_to_ex_valid(id_to_ex_valid), .ex_allowin(ex_allowin),
    .id_pc(id_pc), .id_alu_op(id_alu_op), .id_op_a(id_op_a), .id_op_b(id_op_b),
    .id_rd(id_rd), .id_we(id_we), .id_is_branch(id_is_branch),
    .id_branch_ne(id_branch_ne), .id_is_jal(id_is_jal), .id_target(id_target)
  );

  regfile u_rf (
    .clk(clk), .rst(rst),
    .rs1(rs1), .rs2(rs2), .rdata1(rdata1), .rdata2(rdata2),
    .we(wb_we), .rd(wb_rd), .wdata(wb_data)
  );

  ex_stage u_ex (
    .clk(clk), .rst(rst),
    .id_to_ex_valid(id_to_ex_valid), .ex_allowin(ex_allowin),
    .id_pc(id_pc), .id_alu_op(id_alu_op), .id_op_a(id_op_a), .id_op_b(id_op_b),
    .id_rd(id_rd), .id_we(id_we), .id_is_branch(id_is_branch),
    .id_branch_ne(id_branch_ne), .id_is_jal(id_is_jal), .id_target(id_target),
    .bj_valid(bj_valid), .bj_ena(bj_ena), .bj_pc(bj_pc), .if_bj_ready(if_bj_ready),
    .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
    .retire_valid(retire_valid), .retire_pc(retire_pc),
    .retire_rd(retire_rd), .retire_data(retire_data)
  );

endmodule

`default_nettype wire

// ==== verification/tb_program.svh ====
/*
 * program table for the core testbench
 * instruction words built through the R and I views of inst_u,
 * with the pc, rd and value each one should retire with
 */

`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int PROG_LEN = 28;

typedef struct {
  logic [31:0] inst;
  reg_t        pc;
  reg_idx_t    rd;
  reg_t        data;
  bit          skip;
} prog_entry_t;

prog_entry_t prog [PROG_LEN];
int          prog_fill = 0;

function automatic logic [31:0] imm_op(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                                       logic [11:0] imm);
  inst_u w;
  w.i.opcode = OP_IMM;
  w.i.funct3 = f3;
  w.i.rd     = rd;
  w.i.rs1    = rs1;
  w.i.imm12  = imm;
  return w;
endfunction

function automatic logic [31:0] reg_op(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                       reg_idx_t rs1, reg_idx_t rs2);
  inst_u w;
  w.r.opcode = OP_REG;
  w.r.funct3 = f3;
  w.r.funct7 = f7;
  w.r.rd     = rd;
  w.r.rs1    = rs1;
  w.r.rs2    = rs2;
  return w;
endfunction

// upper 20 bits sit where funct7..funct3 are in the R view
function automatic logic [31:0] lui_op(reg_idx_t rd, logic [19:0] imm20);
  inst_u w;
  w.r.opcode = OP_LUI;
  w.r.rd     = rd;
  {w.r.funct7, w.r.rs2, w.r.rs1, w.r.funct3} = imm20;
  return w;
endfunction

// B-type, offset bits scattered over funct7 and rd
function automatic logic [31:0] branch_op(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                          logic [12:0] off);
  inst_u w;
  w.r.opcode = OP_BRANCH;
  w.r.funct3 = f3;
  w.r.rs1    = rs1;
  w.r.rs2    = rs2;
  w.r.funct7 = {off[12], off[10:5]};
  w.r.rd     = {off[4:1], off[11]};
  return w;
endfunction

// J-type, imm[20|10:1|11|19:12]
function automatic logic [31:0] jal_op(reg_idx_t rd, logic [20:0] off);
  inst_u w;
  w.i.opcode = OP_JAL;
  w.i.rd     = rd;
  w.i.imm12  = {off[20], off[10:1], off[11]};
  w.i.rs1    = off[19:15];
  w.i.funct3 = off[14:12];
  return w;
endfunction

task automatic add_retire(input logic [31:0] inst, input reg_t pc, input reg_idx_t rd,
                          input reg_t data);
  prog[prog_fill] = '{inst, pc, rd, data, 1'b0};
  prog_fill++;
endtask

// jumped over, must never retire
task automatic add_skipped(input logic [31:0] inst);
  prog[prog_fill] = '{inst, reg_t'(0), reg_idx_t'(0), reg_t'(0), 1'b1};
  prog_fill++;
endtask

task automatic build_program();
  add_retire(imm_op(3'b000, 5'd1, 5'd0, 12'h123), 64'h80000000, 5'd1, 64'h123);
  add_retire(imm_op(3'b000, 5'd2, 5'd0, 12'hfff), 64'h80000004, 5'd2, 64'hffffffffffffffff);
  add_retire(imm_op(3'b111, 5'd3, 5'd2, 12'h8f0), 64'h80000008, 5'd3, 64'hfffffffffffff8f0);
  add_retire(imm_op(3'b110, 5'd4, 5'd1, 12'h700), 64'h8000000c, 5'd4, 64'h723);
  add_retire(imm_op(3'b100, 5'd5, 5'd1, 12'h800), 64'h80000010, 5'd5, 64'hfffffffffffff923);
  add_retire(reg_op(7'h00, 3'b000, 5'd6, 5'd1, 5'd4), 64'h80000014, 5'd6, 64'h846);
  add_retire(reg_op(7'h20, 3'b000, 5'd7, 5'd1, 5'd4), 64'h80000018, 5'd7, 64'hfffffffffffffa00);
  add_retire(reg_op(7'h00, 3'b111, 5'd8, 5'd5, 5'd4), 64'h8000001c, 5'd8, 64'h123);
  add_retire(reg_op(7'h00, 3'b110, 5'd9, 5'd3, 5'd1), 64'h80000020, 5'd9, 64'hfffffffffffff9f3);
  add_retire(reg_op(7'h00, 3'b100, 5'd10, 5'd2, 5'd1), 64'h80000024, 5'd10, 64'hfffffffffffffedc);
  add_retire(lui_op(5'd11, 20'h80000), 64'h80000028, 5'd11, 64'hffffffff80000000);
  add_retire(lui_op(5'd12, 20'h12345), 64'h8000002c, 5'd12, 64'h12345000);
  // write to x0 retires with no write, then x0 still reads zero
  add_retire(imm_op(3'b000, 5'd0, 5'd1, 12'h005), 64'h80000030, 5'd0, 64'h0);
  add_retire(imm_op(3'b000, 5'd13, 5'd0, 12'h007), 64'h80000034, 5'd13, 64'h7);
  // beq taken, bne not taken, bne taken, beq not taken
  add_retire(branch_op(3'b000, 5'd1, 5'd8, 13'd8), 64'h80000038, 5'd0, 64'h0);
  add_skipped(imm_op(3'b000, 5'd14, 5'd0, 12'h055));
  add_retire(branch_op(3'b001, 5'd1, 5'd8, 13'd8), 64'h80000040, 5'd0, 64'h0);
  add_retire(branch_op(3'b001, 5'd1, 5'd2, 13'd8), 64'h80000044, 5'd0, 64'h0);
  add_skipped(imm_op(3'b000, 5'd15, 5'd0, 12'h001));
  add_retire(branch_op(3'b000, 5'd1, 5'd2, 13'd12), 64'h8000004c, 5'd0, 64'h0);
  // jal links pc+4 and lands three words on
  add_retire(jal_op(5'd16, 21'd12), 64'h80000050, 5'd16, 64'h80000054);
  add_skipped(imm_op(3'b000, 5'd17, 5'd0, 12'h002));
  add_skipped(imm_op(3'b000, 5'd17, 5'd0, 12'h003));
  add_retire(reg_op(7'h00, 3'b000, 5'd17, 5'd16, 5'd1), 64'h8000005c, 5'd17, 64'h80000177);
  // slli is not supported, no write
  add_retire(imm_op(3'b001, 5'd18, 5'd1, 12'h003), 64'h80000060, 5'd0, 64'h0);
  add_retire(jal_op(5'd0, 21'd8), 64'h80000064, 5'd0, 64'h0);
  add_skipped(imm_op(3'b000, 5'd19, 5'd0, 12'h004));
  add_retire(imm_op(3'b000, 5'd19, 5'd17, 12'he89), 64'h8000006c, 5'd19, 64'h80000000);
endtask

`endif

// ==== verification/tb_core.sv ====
/*
 * testbench for the rv64i core
 * instruction memory with random wait states, retire checking
 * against the program table and a cycle limit
 */

`default_nettype none

module tb_core;
  import rv_pkg::*;

  `include "tb_program.svh"

  localparam int MAX_CYCLES = PROG_LEN * 12 + 20;

  logic           clk;
  logic           rst;
  logic           imem_ready = 1'b0;
  reg_t           imem_rdata = '0;
  wire            imem_valid;
  wire reg_t      imem_addr;
  wire            retire_valid;
  wire reg_t      retire_pc;
  wire reg_idx_t  retire_rd;
  wire reg_t      retire_data;

  int   pc_errors = 0;
  int   rd_errors = 0;
  int   data_errors = 0;
  int   addr_errors = 0;
  int   retired = 0;
  int   expected_retires = 0;
  int   cycles = 0;
  int   seed = 32'h1085;
  int   wait_left = 0;
  logic req_seen = 1'b0;
  reg_t req_addr = '0;

  core_top DUT (
    .clk(clk), .rst(rst),
    .imem_valid(imem_valid), .imem_addr(imem_addr),
    .imem_ready(imem_ready), .imem_rdata(imem_rdata),
    .retire_valid(retire_valid), .retire_pc(retire_pc),
    .retire_rd(retire_rd), .retire_data(retire_data)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // past the end of the table memory returns its own address
  function automatic reg_t fetch_word(reg_t addr);
    reg_t offset;
    offset = addr - 64'h80000000;
    if (offset < reg_t'(PROG_LEN * 4)) begin
      return {32'h0, prog[int'(offset >> 2)].inst};
    end
    return addr;
  endfunction

  // one request at a time, 0 to 3 wait cycles each
  always @(posedge clk) begin
    #1;
    if (rst || !imem_valid) begin
      imem_ready = 1'b0;
      req_seen = 1'b0;
    end else if (!req_seen) begin
      req_seen = 1'b1;
      req_addr = imem_addr;
      wait_left = $random(seed) & 3;
      imem_ready = (wait_left == 0);
    end else begin
      // address must hold through the wait states
      check_addr(imem_addr, req_addr);
      if (!imem_ready) begin
        wait_left = wait_left - 1;
        imem_ready = (wait_left == 0);
      end
    end
    imem_rdata = imem_valid ? fetch_word(imem_addr) : reg_t'(0);
  end

  task automatic check_pc(input reg_t got, input reg_t exp, input int idx);
    if (got !== exp) begin
      pc_errors++;
      $display("CHECK FAILED at %0t: entry %0d retire pc %h, expected %h", $time, idx, got, exp);
    end
  endtask

  task automatic check_rd(input reg_idx_t got, input reg_idx_t exp, input int idx);
    if (got !== exp) begin
      rd_errors++;
      $display("CHECK FAILED at %0t: entry %0d retire rd %0d, expected %0d",
               $time, idx, got, exp);
    end
  endtask

  task automatic check_data(input reg_t got, input reg_t exp, input int idx);
    if (got !== exp) begin
      data_errors++;
      $display("CHECK FAILED at %0t: entry %0d retire data %h, expected %h",
               $time, idx, got, exp);
    end
  endtask

  task automatic check_addr(input reg_t got, input reg_t exp);
    if (got !== exp) begin
      addr_errors++;
      $display("CHECK FAILED at %0t: fetch address %h moved from %h during wait",
               $time, got, exp);
    end
  endtask

  // cycle limit
  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped after %0d cycles, only %0d of %0d instructions retired",
             cycles, retired, expected_retires);
    $display("errors: pc %0d, rd %0d, data %0d, addr %0d",
             pc_errors, rd_errors, data_errors, addr_errors);
    $display("Test failed");
    $finish;
  end

  initial begin
    int i;
    rst = 1'b1;
    build_program();
    for (i = 0; i < PROG_LEN; i++) begin
      if (!prog[i].skip) begin
        expected_retires++;
      end
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // retire outputs are sampled on the falling edge
    for (i = 0; i < PROG_LEN; i++) begin
      if (!prog[i].skip) begin
        @(negedge clk);
        while (!retire_valid) begin
          @(negedge clk);
        end
        check_pc(retire_pc, prog[i].pc, i);
        check_rd(retire_rd, prog[i].rd, i);
        check_data(retire_data, prog[i].data, i);
        retired++;
      end
    end

    $display("errors: pc %0d, rd %0d, data %0d, addr %0d",
             pc_errors, rd_errors, data_errors, addr_errors);
    if (pc_errors + rd_errors + data_errors + addr_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verification
verilog/rv_pkg.sv
verilog/if_stage.sv
verilog/regfile.sv
verilog/id_stage.sv
verilog/ex_stage.sv
verilog/core_top.sv
verification/tb_core.sv

// ==== Makefile ====
# Verilator simulation of the rv64i core

VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
